//--- all.f
+incdir+.
mandel_pkg.sv
result_lane_if.sv
pixel_dispatcher.sv
depth_engine.sv
lane_fifo.sv
depth_matcher.sv
mandel_top.sv
mandel_properties.sv
mandel_checker.sv
tb_mandel.sv

//--- Bender.yml
package:
  name: mandel

sources:
  - include_dirs:
      - .
    files:
      - mandel_pkg.sv
      - result_lane_if.sv
      - pixel_dispatcher.sv
      - depth_engine.sv
      - lane_fifo.sv
      - depth_matcher.sv
      - mandel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mandel_properties.sv
      - mandel_checker.sv
      - tb_mandel.sv

//--- tb_mandel.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module tb_mandel;
    import mandel_pkg::*;

    localparam int PERIOD = 100;
    localparam int NUM_ROWS = 7;
    // cycles each pixel stays up when no match is expected
    localparam int NOMATCH_HOLD = 8;
    // ready-high cycles a pixel may take before it counts as lost
    localparam int PIXEL_WAIT = 2 * (`MAX_ITER + 10);
    localparam logic [31:0] LCG_SEED = 32'h160f;

    // one row of stimulus, names padded to 16 characters
    typedef struct packed {
        logic [8*16-1:0] name;
        int first_x;
        int first_y;
        int count;
        int hold;
        logic random_ready;
        logic expect_match;
        logic launch;
    } test_row_t;

    // name, start pixel, pixel count, ready hold, random ready, match, init_start
    test_row_t tests [NUM_ROWS] = '{
        '{"pre_launch      ", 0, 0, 3, 0, 1'b0, 1'b0, 1'b0},
        '{"first_pixel     ", 0, 0, 1, 0, 1'b0, 1'b1, 1'b1},
        '{"raster_run      ", 1, 0, 39, 0, 1'b0, 1'b1, 1'b0},
        '{"ready_hold      ", 40, 0, 5, 12, 1'b0, 1'b1, 1'b0},
        '{"far_ahead       ", 100, 5, 2, 0, 1'b0, 1'b0, 1'b0},
        '{"resume          ", 45, 0, 5, 0, 1'b0, 1'b1, 1'b0},
        '{"back_pressure   ", 50, 0, 30, 400, 1'b1, 1'b1, 1'b0}
    };

    logic clk;
    logic reset;
    logic init_start;
    x_coord_t pixel_x;
    y_coord_t pixel_y;
    logic ready;
    logic valid_int;
    depth_t depth_out;
    // test framing seen by the checker
    logic test_active;
    logic test_end;
    logic run_done;
    logic expect_match;
    logic [8*16-1:0] test_name;
    int expect_count;
    int error_count;
    logic [31:0] lcg_state;

    mandel_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .init_start(init_start),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .ready     (ready),
        .valid_int (valid_int),
        .depth_out (depth_out)
    );

    mandel_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .ready       (ready),
        .valid_int   (valid_int),
        .depth_out   (depth_out),
        .test_active (test_active),
        .test_end    (test_end),
        .run_done    (run_done),
        .expect_match(expect_match),
        .expect_count(expect_count),
        .test_name   (test_name),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // raster order, wrap at line end and frame end
    function automatic pixel_coord_t raster_step(input pixel_coord_t c);
        pixel_coord_t n;
        n = c;
        if (int'(c.x) == `SCREEN_WIDTH - 1) begin
            n.x = '0;
            n.y = (int'(c.y) == `SCREEN_HEIGHT - 1) ? '0 : c.y + 1'b1;
        end else begin
            n.x = c.x + 1'b1;
        end
        return n;
    endfunction

    // low for the hold, then random or high
    task automatic pick_ready(input int row, input int cyc, output logic rdy);
        if (cyc < tests[row].hold) begin
            rdy = 1'b0;
        end else if (tests[row].random_ready) begin
            lcg_state = lcg_next(lcg_state);
            rdy = lcg_state[16];
        end else begin
            rdy = 1'b1;
        end
    endtask

    // pixel generator model for one table row
    task automatic run_row(input int row);
        pixel_coord_t cur;
        int done_cnt;
        int wait_cnt;
        int cyc;
        logic rdy;
        logic handshake;
        if (tests[row].launch) begin
            @(posedge clk);
            init_start <= 1'b1;
            @(posedge clk);
            init_start <= 1'b0;
        end
        cur.x = x_coord_t'(tests[row].first_x);
        cur.y = y_coord_t'(tests[row].first_y);
        done_cnt = 0;
        wait_cnt = 0;
        cyc = 0;
        pick_ready(row, cyc, rdy);
        @(posedge clk);
        pixel_x <= cur.x;
        pixel_y <= cur.y;
        ready <= rdy;
        test_name <= tests[row].name;
        expect_match <= tests[row].expect_match;
        expect_count <= tests[row].count;
        test_active <= 1'b1;
        while (done_cnt < tests[row].count && wait_cnt <= PIXEL_WAIT) begin
            // handshake seen mid-cycle, taken on the next edge
            @(negedge clk);
            handshake = valid_int && ready;
            cyc++;
            if (tests[row].expect_match) begin
                if (handshake) begin
                    done_cnt++;
                    wait_cnt = 0;
                    cur = raster_step(cur);
                end else if (ready) begin
                    wait_cnt++;
                end
            end else begin
                wait_cnt++;
                if (wait_cnt == NOMATCH_HOLD) begin
                    done_cnt++;
                    wait_cnt = 0;
                    cur = raster_step(cur);
                end
            end
            if (done_cnt < tests[row].count && wait_cnt <= PIXEL_WAIT) begin
                pick_ready(row, cyc, rdy);
                @(posedge clk);
                pixel_x <= cur.x;
                pixel_y <= cur.y;
                ready <= rdy;
            end
        end
        // ready drops so nothing is consumed between rows
        @(posedge clk);
        ready <= 1'b0;
        test_active <= 1'b0;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        init_start = 1'b0;
        pixel_x = '0;
        pixel_y = '0;
        ready = 1'b0;
        test_active = 1'b0;
        test_end = 1'b0;
        run_done = 1'b0;
        expect_match = 1'b0;
        test_name = '0;
        expect_count = 0;
        lcg_state = LCG_SEED;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        @(posedge clk);
        // checker errors and bound assertion failures both count
        if (error_count == 0 && u_dut.u_properties.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget per requested pixel plus the longest ready hold
    initial begin
        longint pixels;
        longint longest_hold;
        longint limit_ns;
        pixels = 0;
        longest_hold = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            pixels += tests[r].count;
            if (tests[r].hold > longest_hold) begin
                longest_hold = tests[r].hold;
            end
        end
        limit_ns = (pixels * (`MAX_ITER + 10) + longest_hold) * PERIOD;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

//--- mandel_checker.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_checker (
    input  logic clk,
    input  logic reset,
    input  mandel_pkg::x_coord_t pixel_x,
    input  mandel_pkg::y_coord_t pixel_y,
    input  logic ready,
    input  logic valid_int,
    input  mandel_pkg::depth_t depth_out,
    input  logic test_active,
    input  logic test_end,
    input  logic run_done,
    input  logic expect_match,
    input  int expect_count,
    input  logic [8*16-1:0] test_name,
    output int error_count
);
    import mandel_pkg::*;

    int test_errors = 0;
    int delivered = 0;
    int tests_run = 0;
    int total_delivered = 0;
    int total_errors = 0;
    // last sample had a match waiting on ready
    logic held = 1'b0;
    depth_t held_depth;
    depth_t expected;

    assign error_count = total_errors;

    // escape-time model, q4.28 with products truncated to one word
    function automatic int model_depth(input int px, input int py);
        int cr;
        int ci;
        int zr;
        int zi;
        int zr_sq;
        int zi_sq;
        int zri;
        int n;
        longint limit;
        cr = `REAL_CENTER + ((px - `SCREEN_WIDTH / 2) <<< `PIXEL_STEP_SHIFT);
        ci = `IMAG_CENTER + ((py - `SCREEN_HEIGHT / 2) <<< `PIXEL_STEP_SHIFT);
        limit = longint'(4) <<< `FRAC;
        zr = 0;
        zi = 0;
        n = 0;
        while (n < `MAX_ITER) begin
            zr_sq = int'((longint'(zr) * zr) >>> `FRAC);
            zi_sq = int'((longint'(zi) * zi) >>> `FRAC);
            zri = int'((longint'(zr) * zi) >>> `FRAC);
            // magnitude from the truncated squares, no wrap
            if (longint'(zr_sq) + longint'(zi_sq) > limit) begin
                break;
            end
            zr = zr_sq - zi_sq + cr;
            zi = zri * 2 + ci;
            n++;
        end
        return n;
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (test_active && !reset) begin
            if (expect_match && valid_int) begin
                expected = depth_t'(model_depth(pixel_x, pixel_y));
                if (depth_out !== expected) begin
                    $display("** Error depth_out at (%0d,%0d): expected 0x%03h, actual 0x%03h",
                        pixel_x, pixel_y, expected, depth_out);
                    test_errors++;
                end
            end
            if (!expect_match && valid_int !== 1'b0) begin
                $display("** Error valid_int at (%0d,%0d): expected 0x0, actual 0x%h",
                    pixel_x, pixel_y, valid_int);
                test_errors++;
            end
            // stalled match must stay put
            if (held && valid_int !== 1'b1) begin
                $display("** Error valid_int during ready low: expected 0x1, actual 0x%h",
                    valid_int);
                test_errors++;
            end
            if (held && depth_out !== held_depth) begin
                $display("** Error depth_out during ready low: expected 0x%03h, actual 0x%03h",
                    held_depth, depth_out);
                test_errors++;
            end
            if (expect_match && valid_int && ready) begin
                delivered++;
            end
            held = valid_int && !ready;
            held_depth = depth_out;
        end else begin
            held = 1'b0;
        end
        if (test_end) begin
            if (expect_match && delivered < expect_count) begin
                $display("%s missed results, only %0d of %0d pixels arrived",
                    test_name, delivered, expect_count);
                test_errors++;
            end
            $display("%s %0d pixels delivered, %0d errors", test_name, delivered, test_errors);
            total_errors += test_errors;
            total_delivered += delivered;
            tests_run++;
            delivered = 0;
            test_errors = 0;
        end
        if (run_done) begin
            $display("summary: %0d tests, %0d pixels delivered, %0d errors",
                tests_run, total_delivered, total_errors);
        end
    end

endmodule

//--- mandel_properties.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_properties (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic valid_int,
    input mandel_pkg::depth_t depth_out,
    result_lane_if lanes [`NUM_ENGINES]
);

    // count of failed assertions
    int fail_count = 0;

    // nothing matches while in reset
    valid_in_reset: assert property (@(posedge clk) reset |-> !valid_int)
        else begin
            fail_count++;
            $error("valid_int high during reset");
        end

    // a match waiting on ready keeps its depth
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        valid_int && !ready |=> valid_int && $stable(depth_out))
        else begin
            fail_count++;
            $error("depth_out changed while ready was low");
        end

    for (genvar g = 0; g < `NUM_ENGINES; g++) begin : g_lane
        // head only moves on a pop
        head_hold: assert property (@(posedge clk) disable iff (reset)
            !lanes[g].empty && !lanes[g].rd_en |=>
                !lanes[g].empty && $stable(lanes[g].head))
            else begin
                fail_count++;
                $error("lane %0d head changed without a pop", g);
            end
        // an accepted write leaves the lane non-empty
        write_lands: assert property (@(posedge clk) disable iff (reset)
            lanes[g].wr_en |=> !lanes[g].empty)
            else begin
                fail_count++;
                $error("lane %0d empty after a write", g);
            end
    end

endmodule

bind mandel_top mandel_properties u_properties (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .valid_int(valid_int),
    .depth_out(depth_out),
    .lanes    (lane_bus)
);

//--- mandel_top.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandel_top (
    input  logic clk,
    input  logic reset,
    input  logic init_start,
    input  mandel_pkg::x_coord_t pixel_x,
    input  mandel_pkg::y_coord_t pixel_y,
    input  logic ready,
    output logic valid_int,
    output mandel_pkg::depth_t depth_out
);
    import mandel_pkg::*;

    logic [`NUM_ENGINES-1:0] engine_start;
    logic [`NUM_ENGINES-1:0] engine_written;
    pixel_coord_t engine_coord [`NUM_ENGINES];

    // one result lane per engine
    result_lane_if lane_bus [`NUM_ENGINES] ();

    pixel_dispatcher u_dispatcher (
        .clk            (clk),
        .reset          (reset),
        .init_start     (init_start),
        .engine_written (engine_written),
        .engine_start   (engine_start),
        .engine_coord   (engine_coord)
    );

    for (genvar g = 0; g < `NUM_ENGINES; g++) begin : g_engine
        depth_engine u_engine (
            .clk     (clk),
            .reset   (reset),
            .start   (engine_start[g]),
            .coord   (engine_coord[g]),
            .written (engine_written[g]),
            .lane    (lane_bus[g])
        );

        lane_fifo u_fifo (
            .clk   (clk),
            .reset (reset),
            .lane  (lane_bus[g])
        );
    end

    depth_matcher u_matcher (
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .ready     (ready),
        .lanes     (lane_bus),
        .valid_int (valid_int),
        .depth_out (depth_out)
    );

endmodule

//--- depth_matcher.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module depth_matcher (
    input  mandel_pkg::x_coord_t pixel_x,
    input  mandel_pkg::y_coord_t pixel_y,
    input  logic ready,
    result_lane_if.read lanes [`NUM_ENGINES],
    output logic valid_int,
    output mandel_pkg::depth_t depth_out
);
    import mandel_pkg::*;

    logic [`NUM_ENGINES-1:0] lane_empty;
    lane_result_t lane_head [`NUM_ENGINES];
    logic [`NUM_ENGINES-1:0] lane_pop;
    lane_idx_t match_idx;

    // flatten the interface array for indexed access
    for (genvar g = 0; g < `NUM_ENGINES; g++) begin : g_lane
        assign lane_empty[g] = lanes[g].empty;
        assign lane_head[g] = lanes[g].head;
        assign lanes[g].rd_en = lane_pop[g];
    end

    // scan from the top so the lowest matching lane is left standing
    always_comb begin
        valid_int = 1'b0;
        match_idx = '0;
        depth_out = '0;
        for (int i = `NUM_ENGINES - 1; i >= 0; i--) begin
            if (!lane_empty[i] && lane_head[i].coord.x == pixel_x &&
                lane_head[i].coord.y == pixel_y) begin
                valid_int = 1'b1;
                match_idx = lane_idx_t'(i);
                depth_out = lane_head[i].depth;
            end
        end
    end

    // pop the winner on the same edge it is taken
    always_comb begin
        lane_pop = '0;
        if (valid_int && ready) begin
            lane_pop[match_idx] = 1'b1;
        end
    end

endmodule

//--- lane_fifo.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module lane_fifo (
    input logic clk,
    input logic reset,
    result_lane_if.buffer lane
);
    import mandel_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    lane_result_t mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_write;
    logic do_read;

    assign do_write = lane.wr_en && !lane.full;
    assign do_read = lane.rd_en && !lane.empty;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= lane.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign lane.full = (count == CNT_W'(`FIFO_DEPTH));
    assign lane.empty = (count == '0);
    // oldest entry, valid while not empty
    assign lane.head = mem[rd_ptr];

endmodule

//--- depth_engine.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module depth_engine (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  mandel_pkg::pixel_coord_t coord,
    output logic written,
    result_lane_if.write lane
);
    import mandel_pkg::*;

    typedef enum logic [1:0] {IDLE, ITER, WRITE} state_t;

    // 4.0 in q4.28
    localparam logic signed [`WORD_LENGTH+1:0] ESCAPE_LIMIT = 4 <<< `FRAC;

    state_t state;
    pixel_coord_t coord_q;
    fixed_t c_re;
    fixed_t c_im;
    fixed_t zr;
    fixed_t zi;
    depth_t count;
    fixed_t x_off;
    fixed_t y_off;
    logic signed [2*`WORD_LENGTH-1:0] zr_sq_full;
    logic signed [2*`WORD_LENGTH-1:0] zi_sq_full;
    logic signed [2*`WORD_LENGTH-1:0] zri_full;
    fixed_t zr_sq;
    fixed_t zi_sq;
    fixed_t zri;
    logic signed [`WORD_LENGTH+1:0] mag_sq;
    logic escaped;

    always_comb begin
        // pixel offset from screen centre
        x_off = fixed_t'(coord.x) - fixed_t'(`SCREEN_WIDTH / 2);
        y_off = fixed_t'(coord.y) - fixed_t'(`SCREEN_HEIGHT / 2);
        // full products, rescaled and cut back to one word
        zr_sq_full = zr * zr;
        zi_sq_full = zi * zi;
        zri_full = zr * zi;
        zr_sq = fixed_t'(zr_sq_full >>> `FRAC);
        zi_sq = fixed_t'(zi_sq_full >>> `FRAC);
        zri = fixed_t'(zri_full >>> `FRAC);
        // two extra bits so the sum itself cannot wrap
        mag_sq = zr_sq + zi_sq;
        escaped = mag_sq > ESCAPE_LIMIT;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            written <= 1'b0;
        end else begin
            written <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        coord_q <= coord;
                        c_re <= `REAL_CENTER + (x_off <<< `PIXEL_STEP_SHIFT);
                        c_im <= `IMAG_CENTER + (y_off <<< `PIXEL_STEP_SHIFT);
                        zr <= '0;
                        zi <= '0;
                        count <= '0;
                        state <= ITER;
                    end
                end
                ITER: begin
                    // test before each update, depth counts updates done
                    if (escaped || count == depth_t'(`MAX_ITER)) begin
                        state <= WRITE;
                    end else begin
                        zr <= zr_sq - zi_sq + c_re;
                        zi <= (zri <<< 1) + c_im;
                        count <= count + 1'b1;
                    end
                end
                WRITE: begin
                    // hold result until the fifo has room
                    if (!lane.full) begin
                        written <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign lane.wr_en = (state == WRITE) && !lane.full;
    assign lane.wr_data = '{coord: coord_q, depth: count};

endmodule

//--- pixel_dispatcher.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module pixel_dispatcher (
    input  logic clk,
    input  logic reset,
    input  logic init_start,
    input  logic [`NUM_ENGINES-1:0] engine_written,
    output logic [`NUM_ENGINES-1:0] engine_start,
    output mandel_pkg::pixel_coord_t engine_coord [`NUM_ENGINES]
);
    import mandel_pkg::*;

    logic started;
    logic launch;
    // next raster coordinate not yet handed out
    pixel_coord_t next_coord;
    pixel_coord_t walk_coord;
    pixel_coord_t coord_d [`NUM_ENGINES];

    // step one pixel in raster order, wrap at line and frame end
    function automatic pixel_coord_t raster_next(input pixel_coord_t c);
        pixel_coord_t n;
        n = c;
        if (c.x == `SCREEN_WIDTH - 1) begin
            n.x = '0;
            if (c.y == `SCREEN_HEIGHT - 1) begin
                n.y = '0;
            end else begin
                n.y = c.y + 1'b1;
            end
        end else begin
            n.x = c.x + 1'b1;
        end
        return n;
    endfunction

    // only the first init_start counts
    assign launch = init_start && !started;

    // lanes that finished take coordinates in index order
    always_comb begin
        walk_coord = next_coord;
        for (int i = 0; i < `NUM_ENGINES; i++) begin
            coord_d[i] = engine_coord[i];
            if (engine_written[i]) begin
                coord_d[i] = walk_coord;
                walk_coord = raster_next(walk_coord);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            engine_start <= '0;
            next_coord <= '{y: '0, x: x_coord_t'(`NUM_ENGINES)};
            // lane i starts on pixel (i, 0)
            for (int i = 0; i < `NUM_ENGINES; i++) begin
                engine_coord[i] <= '{y: '0, x: x_coord_t'(i)};
            end
        end else begin
            if (launch) begin
                started <= 1'b1;
            end
            // restart every lane that just wrote, plus all lanes on launch
            engine_start <= engine_written | {`NUM_ENGINES{launch}};
            next_coord <= walk_coord;
            engine_coord <= coord_d;
        end
    end

endmodule

//--- result_lane_if.sv
`timescale 1ns/1ps

interface result_lane_if;

    // write side, engine to fifo
    logic wr_en;
    mandel_pkg::lane_result_t wr_data;
    logic full;

    // read side, fifo to matcher
    logic empty;
    mandel_pkg::lane_result_t head;
    logic rd_en;

    // engine end
    modport write (output wr_en, output wr_data, input full);

    // fifo end, sees both sides
    modport buffer (
        input wr_en,
        input wr_data,
        output full,
        output empty,
        output head,
        input rd_en
    );

    // matcher end
    modport read (input empty, input head, output rd_en);

endinterface

//--- mandel_pkg.sv
`include "mandel_defines.svh"

package mandel_pkg;

    // pixel coordinates
    typedef logic [$clog2(`SCREEN_WIDTH)-1:0] x_coord_t;
    typedef logic [$clog2(`SCREEN_HEIGHT)-1:0] y_coord_t;

    // y in the upper bits, x below
    typedef struct packed {
        y_coord_t y;
        x_coord_t x;
    } pixel_coord_t;

    // iteration count
    typedef logic [9:0] depth_t;

    // signed q4.28
    typedef logic signed [`WORD_LENGTH-1:0] fixed_t;

    // lane fifo entry, coordinate tag plus depth
    typedef struct packed {
        pixel_coord_t coord;
        depth_t depth;
    } lane_result_t;

    typedef logic [$clog2(`NUM_ENGINES)-1:0] lane_idx_t;

endpackage

//--- mandel_defines.svh
`ifndef MANDEL_DEFINES_SVH
`define MANDEL_DEFINES_SVH

// raster geometry
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// one lane fifo per engine
`define NUM_ENGINES 5
`define MAX_ITER 200

// q4.28 fixed point
`define FRAC 28
`define WORD_LENGTH 32

// screen centre at -0.5 + 0i
`define REAL_CENTER 32'shF800_0000
`define IMAG_CENTER 32'sh0000_0000

// one pixel is 1/256, i.e. 1 << 20 in q4.28
`define PIXEL_STEP_SHIFT 20

// kept small so back-pressure shows up quickly
`define FIFO_DEPTH 4

`endif
